// File: verilog/rv_pkg.sv
////////////////////////////////////////////////////////////
// rv_pkg: shared RV32I slice types, opcodes and stage payloads
////////////////////////////////////////////////////////////

package rv_pkg;

    localparam int XLEN = 32;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_ALU_I  = 7'b0010011;
    localparam logic [6:0] OP_ALU    = 7'b0110011;

    // alu funct3, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;
    // free branch code, marks an unconditional jump
    localparam logic [2:0] F3_JUMP = 3'b010;

    localparam logic [6:0] F7_NORMAL  = 7'b0000000;
    localparam logic [6:0] F7_SUB_SRA = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } stype_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } btype_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } utype_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jtype_t;

    // one instruction word, read through whichever format applies
    typedef union packed {
        rtype_t rtype;
        itype_t itype;
        stype_t stype;
        btype_t btype;
        utype_t utype;
        jtype_t jtype;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic {
        UNIT_ALU,
        UNIT_BRANCH
    } unit_t;

    // standard mcause codes
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        ILLEGAL_INSTR         = 4'd2
    } exc_cause_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        instr_t          inst;
    } fetch_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [XLEN-1:0] imm;
        alu_op_t         alu_op;
        logic [2:0]      funct3;
        unit_t           unit;
        logic            use_imm;
        logic            use_pc;
        logic            is_jalr;
        logic            reg_we;
        logic            illegal;
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            reg_we;
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] next_pc;
        logic            exc_valid;
        exc_cause_t      exc_cause;
    } result_t;

endpackage

// File: verilog/rv_immediate.sv
////////////////////////////////////////////////////////////
// rv_immediate: sign-extended immediate per instruction format
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_immediate (
    input  rv_pkg::instr_t          inst_i,
    output logic [rv_pkg::XLEN-1:0] imm_o
);

    always_comb begin
        case (inst_i.rtype.opcode)
            rv_pkg::OP_ALU_I, rv_pkg::OP_JALR: begin
                imm_o = {{20{inst_i.itype.imm[11]}}, inst_i.itype.imm};
            end
            rv_pkg::OP_STORE: begin
                imm_o = {{20{inst_i.stype.imm_hi[6]}}, inst_i.stype.imm_hi,
                         inst_i.stype.imm_lo};
            end
            rv_pkg::OP_BRANCH: begin
                imm_o = {{20{inst_i.btype.imm_12}}, inst_i.btype.imm_11,
                         inst_i.btype.imm_10_5, inst_i.btype.imm_4_1, 1'b0};
            end
            rv_pkg::OP_LUI, rv_pkg::OP_AUIPC: begin
                imm_o = {inst_i.utype.imm_31_12, 12'b0};
            end
            rv_pkg::OP_JAL: begin
                imm_o = {{12{inst_i.jtype.imm_20}}, inst_i.jtype.imm_19_12,
                         inst_i.jtype.imm_11, inst_i.jtype.imm_10_1, 1'b0};
            end
            // r-type and unsupported opcodes
            default: imm_o = '0;
        endcase
    end

endmodule

// File: verilog/rv_decoder.sv
////////////////////////////////////////////////////////////
// rv_decoder: RV32I integer word to control entry, flags illegal
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::fetch_t   fetch_i,
    output rv_pkg::decoded_t decoded_o
);

    logic [rv_pkg::XLEN-1:0] imm;

    rv_immediate i_rv_immediate (
        .inst_i(fetch_i.inst),
        .imm_o (imm)
    );

    // alu op for funct3 when funct7 is the normal encoding
    function automatic rv_pkg::alu_op_t base_op(input logic [2:0] f3);
        case (f3)
            rv_pkg::F3_SLL:     return rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:     return rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU:    return rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:     return rv_pkg::ALU_XOR;
            rv_pkg::F3_SRL_SRA: return rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:      return rv_pkg::ALU_OR;
            rv_pkg::F3_AND:     return rv_pkg::ALU_AND;
            default:            return rv_pkg::ALU_ADD;
        endcase
    endfunction

    always_comb begin
        decoded_o.pc     = fetch_i.pc;
        decoded_o.rs1    = fetch_i.inst.rtype.rs1;
        decoded_o.rs2    = fetch_i.inst.rtype.rs2;
        decoded_o.rd     = fetch_i.inst.rtype.rd;
        decoded_o.imm    = imm;
        decoded_o.funct3 = fetch_i.inst.rtype.funct3;
        // all enables off until the opcode says otherwise
        decoded_o.alu_op  = rv_pkg::ALU_ADD;
        decoded_o.unit    = rv_pkg::UNIT_ALU;
        decoded_o.use_imm = 1'b0;
        decoded_o.use_pc  = 1'b0;
        decoded_o.is_jalr = 1'b0;
        decoded_o.reg_we  = 1'b0;
        decoded_o.illegal = 1'b0;

        case (fetch_i.inst.rtype.opcode)
            rv_pkg::OP_LUI: begin
                // x0 | imm
                decoded_o.rs1     = '0;
                decoded_o.rs2     = '0;
                decoded_o.use_imm = 1'b1;
                decoded_o.alu_op  = rv_pkg::ALU_OR;
                decoded_o.reg_we  = 1'b1;
            end
            rv_pkg::OP_AUIPC: begin
                decoded_o.rs1     = '0;
                decoded_o.rs2     = '0;
                decoded_o.use_imm = 1'b1;
                decoded_o.use_pc  = 1'b1;
                decoded_o.reg_we  = 1'b1;
            end
            rv_pkg::OP_JAL: begin
                decoded_o.rs1     = '0;
                decoded_o.rs2     = '0;
                decoded_o.use_imm = 1'b1;
                decoded_o.use_pc  = 1'b1;
                decoded_o.unit    = rv_pkg::UNIT_BRANCH;
                decoded_o.funct3  = rv_pkg::F3_JUMP;
                decoded_o.reg_we  = 1'b1;
            end
            rv_pkg::OP_JALR: begin
                decoded_o.rs2     = '0;
                decoded_o.use_imm = 1'b1;
                decoded_o.is_jalr = 1'b1;
                decoded_o.unit    = rv_pkg::UNIT_BRANCH;
                decoded_o.funct3  = rv_pkg::F3_JUMP;
                decoded_o.reg_we  = 1'b1;
                decoded_o.illegal = fetch_i.inst.itype.funct3 != rv_pkg::F3_JALR;
            end
            rv_pkg::OP_BRANCH: begin
                decoded_o.use_imm = 1'b1;
                decoded_o.use_pc  = 1'b1;
                decoded_o.unit    = rv_pkg::UNIT_BRANCH;
                // 010 and 011 are not branches
                decoded_o.illegal = fetch_i.inst.btype.funct3[2:1] == 2'b01;
            end
            rv_pkg::OP_ALU_I: begin
                decoded_o.rs2     = '0;
                decoded_o.use_imm = 1'b1;
                decoded_o.reg_we  = 1'b1;
                decoded_o.alu_op  = base_op(fetch_i.inst.itype.funct3);
                case (fetch_i.inst.itype.funct3)
                    rv_pkg::F3_SLL: begin
                        decoded_o.illegal = fetch_i.inst.rtype.funct7 != rv_pkg::F7_NORMAL;
                    end
                    rv_pkg::F3_SRL_SRA: begin
                        case (fetch_i.inst.rtype.funct7)
                            rv_pkg::F7_SUB_SRA: decoded_o.alu_op = rv_pkg::ALU_SRA;
                            rv_pkg::F7_NORMAL:  decoded_o.alu_op = rv_pkg::ALU_SRL;
                            default:            decoded_o.illegal = 1'b1;
                        endcase
                    end
                    default: ;
                endcase
            end
            rv_pkg::OP_ALU: begin
                decoded_o.reg_we = 1'b1;
                decoded_o.alu_op = base_op(fetch_i.inst.rtype.funct3);
                if (fetch_i.inst.rtype.funct7 == rv_pkg::F7_SUB_SRA) begin
                    // only add and srl have an alternate form
                    case (fetch_i.inst.rtype.funct3)
                        rv_pkg::F3_ADD_SUB: decoded_o.alu_op = rv_pkg::ALU_SUB;
                        rv_pkg::F3_SRL_SRA: decoded_o.alu_op = rv_pkg::ALU_SRA;
                        default:            decoded_o.illegal = 1'b1;
                    endcase
                end else if (fetch_i.inst.rtype.funct7 != rv_pkg::F7_NORMAL) begin
                    decoded_o.illegal = 1'b1;
                end
            end
            // loads, stores, fence, system, w ops
            default: decoded_o.illegal = 1'b1;
        endcase

        // illegal words and x0 targets never write; rd only names real writes
        if (decoded_o.illegal || decoded_o.rd == '0) begin
            decoded_o.reg_we = 1'b0;
        end
        if (!decoded_o.reg_we) begin
            decoded_o.rd = '0;
        end
    end

endmodule

// File: verilog/rv_regfile.sv
////////////////////////////////////////////////////////////
// rv_regfile: 32 x XLEN registers with pending-write scoreboard
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic [4:0]              rs1_i,
    input  logic [4:0]              rs2_i,
    output logic [rv_pkg::XLEN-1:0] rs1_data_o,
    output logic [rv_pkg::XLEN-1:0] rs2_data_o,
    output logic                    hazard_o,
    input  logic                    claim_i,
    input  logic [4:0]              claim_rd_i,
    input  logic                    wr_en_i,
    input  logic [4:0]              wr_rd_i,
    input  logic [rv_pkg::XLEN-1:0] wr_data_i
);

    logic [rv_pkg::XLEN-1:0] regs_q [32];
    logic [31:0]             pending_q;

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

    // claim_rd_i is the incoming rd, so a second writer of a pending reg waits too
    assign hazard_o = pending_q[rs1_i] | pending_q[rs2_i] | pending_q[claim_rd_i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (wr_en_i) begin
                regs_q[wr_rd_i] <= wr_data_i;
            end
            // wr_rd_i is zero outside a retirement
            pending_q <= (pending_q & ~(32'b1 << wr_rd_i)) | ({31'b0, claim_i} << claim_rd_i);
        end
    end

    claim_not_x0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        claim_i |-> claim_rd_i != '0);

endmodule

// File: verilog/rv_execute.sv
////////////////////////////////////////////////////////////
// rv_execute: execute register, ALU, branch compare, next pc
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_execute (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  rv_pkg::decoded_t        decoded_i,
    input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    input  logic                    hazard_i,
    output logic                    claim_o,
    output logic [4:0]              claim_rd_o,
    output logic                    ex_valid_o,
    input  logic                    ex_ready_i,
    output rv_pkg::result_t         ex_result_o
);

    logic                    valid_q;
    rv_pkg::decoded_t        entry_q;
    logic [rv_pkg::XLEN-1:0] rs1_q;
    logic [rv_pkg::XLEN-1:0] rs2_q;
    logic                    accept;
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic [rv_pkg::XLEN-1:0] pc_plus4;
    logic [rv_pkg::XLEN-1:0] target;
    logic                    cond;
    logic                    taken;
    logic                    misaligned;

    // free, or draining this cycle, and no pending source
    assign in_ready_o = (!valid_q || ex_ready_i) && !hazard_i;
    assign accept     = in_valid_i && in_ready_o;
    assign claim_o    = accept && decoded_i.reg_we;
    assign claim_rd_o = decoded_i.rd;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (ex_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            entry_q <= decoded_i;
            rs1_q   <= rs1_data_i;
            rs2_q   <= rs2_data_i;
        end
    end

    assign op_a     = entry_q.use_pc ? entry_q.pc : rs1_q;
    assign op_b     = entry_q.use_imm ? entry_q.imm : rs2_q;
    assign pc_plus4 = entry_q.pc + 32'd4;
    // pc+imm or rs1+imm, jalr drops bit 0
    assign target   = (op_a + entry_q.imm) & {{(rv_pkg::XLEN-1){1'b1}}, !entry_q.is_jalr};

    always_comb begin
        case (entry_q.alu_op)
            rv_pkg::ALU_ADD:  alu_res = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rv_pkg::ALU_SLL:  alu_res = op_a << op_b[4:0];
            rv_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_res = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            rv_pkg::ALU_OR:   alu_res = op_a | op_b;
            default:          alu_res = op_a & op_b;
        endcase
    end

    always_comb begin
        case (entry_q.funct3)
            rv_pkg::F3_BEQ:  cond = rs1_q == rs2_q;
            rv_pkg::F3_BNE:  cond = rs1_q != rs2_q;
            rv_pkg::F3_BLT:  cond = $signed(rs1_q) < $signed(rs2_q);
            rv_pkg::F3_BGE:  cond = $signed(rs1_q) >= $signed(rs2_q);
            rv_pkg::F3_BLTU: cond = rs1_q < rs2_q;
            rv_pkg::F3_JUMP: cond = 1'b1;
            default:         cond = rs1_q >= rs2_q;
        endcase
    end

    assign taken      = entry_q.unit == rv_pkg::UNIT_BRANCH && cond;
    assign misaligned = taken && target[1];

    always_comb begin
        ex_result_o.pc        = entry_q.pc;
        ex_result_o.rd        = entry_q.rd;
        ex_result_o.reg_we    = entry_q.reg_we && !misaligned;
        ex_result_o.value     = (entry_q.unit == rv_pkg::UNIT_BRANCH) ? pc_plus4 : alu_res;
        ex_result_o.exc_valid = entry_q.illegal || misaligned;
        ex_result_o.exc_cause = entry_q.illegal ? rv_pkg::ILLEGAL_INSTR
                                                : rv_pkg::INSTR_ADDR_MISALIGNED;
        ex_result_o.next_pc   = (taken && !ex_result_o.exc_valid) ? target : pc_plus4;
    end

    assign ex_valid_o = valid_q;

    ex_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ex_valid_o && !ex_ready_i |=> ex_valid_o && $stable(ex_result_o));

endmodule

// File: verilog/rv_result.sv
////////////////////////////////////////////////////////////
// rv_result: retire register, output stream and writeback
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_result (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ex_valid_i,
    output logic                    ex_ready_o,
    input  rv_pkg::result_t         ex_result_i,
    output logic                    res_valid_o,
    input  logic                    res_ready_i,
    output rv_pkg::result_t         res_o,
    output logic                    wr_en_o,
    output logic [4:0]              wr_rd_o,
    output logic [rv_pkg::XLEN-1:0] wr_data_o
);

    logic            valid_q;
    rv_pkg::result_t res_q;
    logic            xfer;

    assign ex_ready_o = !valid_q || res_ready_i;
    assign xfer       = valid_q && res_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ex_valid_i && ex_ready_o) begin
            valid_q <= 1'b1;
        end else if (res_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_valid_i && ex_ready_o) begin
            res_q <= ex_result_i;
        end
    end

    assign res_valid_o = valid_q;
    assign res_o       = res_q;

    // rd also clears the pending bit when an exception blocked the write
    assign wr_en_o   = xfer && res_q.reg_we;
    assign wr_rd_o   = xfer ? res_q.rd : '0;
    assign wr_data_o = res_q.value;

    no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_en_o |-> wr_rd_o != '0);

endmodule

// File: verilog/rv_int_slice.sv
////////////////////////////////////////////////////////////
// rv_int_slice: RV32I integer slice, decode, execute, retire
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_int_slice (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  rv_pkg::fetch_t  fetch_i,
    output logic            res_valid_o,
    input  logic            res_ready_i,
    output rv_pkg::result_t res_o
);

    rv_pkg::decoded_t        decoded;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic                    hazard;
    logic                    claim;
    logic [4:0]              claim_rd;
    logic                    ex_valid;
    logic                    ex_ready;
    rv_pkg::result_t         ex_result;
    logic                    wr_en;
    logic [4:0]              wr_rd;
    logic [rv_pkg::XLEN-1:0] wr_data;

    rv_decoder i_rv_decoder (
        .fetch_i  (fetch_i),
        .decoded_o(decoded)
    );

    rv_regfile i_rv_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rs1_i     (decoded.rs1),
        .rs2_i     (decoded.rs2),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .hazard_o  (hazard),
        .claim_i   (claim),
        .claim_rd_i(claim_rd),
        .wr_en_i   (wr_en),
        .wr_rd_i   (wr_rd),
        .wr_data_i (wr_data)
    );

    rv_execute i_rv_execute (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .decoded_i  (decoded),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .hazard_i   (hazard),
        .claim_o    (claim),
        .claim_rd_o (claim_rd),
        .ex_valid_o (ex_valid),
        .ex_ready_i (ex_ready),
        .ex_result_o(ex_result)
    );

    rv_result i_rv_result (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ex_valid_i (ex_valid),
        .ex_ready_o (ex_ready),
        .ex_result_i(ex_result),
        .res_valid_o(res_valid_o),
        .res_ready_i(res_ready_i),
        .res_o      (res_o),
        .wr_en_o    (wr_en),
        .wr_rd_o    (wr_rd),
        .wr_data_o  (wr_data)
    );

endmodule

// File: dv/rv_tb_table.svh
////////////////////////////////////////////////////////////
// program table for the integer slice testbench
////////////////////////////////////////////////////////////
`ifndef RV_TB_TABLE_SVH
`define RV_TB_TABLE_SVH

// each row gives name, pc, inst, rd, reg_we, value, next_pc, exc_valid and exc_cause
// value and rd only matter when reg_we is set, cause only with exc_valid
task automatic load_table();
    add_row("addi x1,x0,5",      'h1000, 'h00500093, 1, 1, 'h00000005, 'h1004, 0, 0);
    add_row("addi x2,x0,-3",     'h1004, 'hFFD00113, 2, 1, 'hFFFFFFFD, 'h1008, 0, 0);
    add_row("slti x3,x2,1",      'h1008, 'h00112193, 3, 1, 'h00000001, 'h100C, 0, 0);
    add_row("xori x4,x1,0f0",    'h100C, 'h0F00C213, 4, 1, 'h000000F5, 'h1010, 0, 0);
    add_row("ori x5,x4,700",     'h1010, 'h70026293, 5, 1, 'h000007F5, 'h1014, 0, 0);
    add_row("andi x6,x5,0ff",    'h1014, 'h0FF2F313, 6, 1, 'h000000F5, 'h1018, 0, 0);
    add_row("slli x7,x1,28",     'h1018, 'h01C09393, 7, 1, 'h50000000, 'h101C, 0, 0);
    add_row("srli x8,x2,4",      'h101C, 'h00415413, 8, 1, 'h0FFFFFFF, 'h1020, 0, 0);
    add_row("srai x9,x2,1",      'h1020, 'h40115493, 9, 1, 'hFFFFFFFE, 'h1024, 0, 0);
    add_row("add x10,x1,x3",     'h1024, 'h00308533, 10, 1, 'h00000006, 'h1028, 0, 0);
    add_row("sub x11,x10,x1",    'h1028, 'h401505B3, 11, 1, 'h00000001, 'h102C, 0, 0);
    add_row("slt x12,x2,x11",    'h102C, 'h00B12633, 12, 1, 'h00000001, 'h1030, 0, 0);
    add_row("sltu x13,x2,x12",   'h1030, 'h00C136B3, 13, 1, 'h00000000, 'h1034, 0, 0);
    add_row("sll x14,x1,x12",    'h1034, 'h00C09733, 14, 1, 'h0000000A, 'h1038, 0, 0);
    add_row("sra x15,x2,x14",    'h1038, 'h40E157B3, 15, 1, 'hFFFFFFFF, 'h103C, 0, 0);
    add_row("srl x16,x15,x14",   'h103C, 'h00E7D833, 16, 1, 'h003FFFFF, 'h1040, 0, 0);
    add_row("xor x17,x16,x6",    'h1040, 'h006848B3, 17, 1, 'h003FFF0A, 'h1044, 0, 0);
    add_row("or x18,x17,x7",     'h1044, 'h0078E933, 18, 1, 'h503FFF0A, 'h1048, 0, 0);
    add_row("and x19,x18,x5",    'h1048, 'h005979B3, 19, 1, 'h00000700, 'h104C, 0, 0);
    add_row("lui x20,12345",     'h104C, 'h12345A37, 20, 1, 'h12345000, 'h1050, 0, 0);
    add_row("auipc x21,1",       'h1050, 'h00001A97, 21, 1, 'h00002050, 'h1054, 0, 0);
    add_row("jal x22,+16",       'h1054, 'h01000B6F, 22, 1, 'h00001058, 'h1064, 0, 0);
    add_row("jalr x23,9(x22)",   'h1058, 'h009B0BE7, 23, 1, 'h0000105C, 'h1060, 0, 0);
    add_row("beq taken",         'h105C, 'h00B18463, 0, 0, 'h0, 'h1064, 0, 0);
    add_row("beq not taken",     'h1060, 'h00308463, 0, 0, 'h0, 'h1064, 0, 0);
    add_row("bne taken back",    'h1064, 'hFE3098E3, 0, 0, 'h0, 'h1054, 0, 0);
    add_row("bne not taken",     'h1068, 'h00B19463, 0, 0, 'h0, 'h106C, 0, 0);
    add_row("blt taken",         'h106C, 'h00114463, 0, 0, 'h0, 'h1074, 0, 0);
    add_row("blt not taken",     'h1070, 'h0020C463, 0, 0, 'h0, 'h1074, 0, 0);
    add_row("bge taken",         'h1074, 'h0020D463, 0, 0, 'h0, 'h107C, 0, 0);
    add_row("bge not taken",     'h1078, 'h00115463, 0, 0, 'h0, 'h107C, 0, 0);
    add_row("bltu taken",        'h107C, 'h0020E463, 0, 0, 'h0, 'h1084, 0, 0);
    add_row("bltu not taken",    'h1080, 'h00116463, 0, 0, 'h0, 'h1084, 0, 0);
    add_row("bgeu taken back",   'h1084, 'hFE1178E3, 0, 0, 'h0, 'h1074, 0, 0);
    add_row("bgeu not taken",    'h1088, 'h0020F463, 0, 0, 'h0, 'h108C, 0, 0);
    add_row("lw x24 illegal",    'h108C, 'h0000AC03, 0, 0, 'h0, 'h1090, 1, 2);
    add_row("slli bad funct7",   'h1090, 'h02309C93, 0, 0, 'h0, 'h1094, 1, 2);
    add_row("add bad funct7",    'h1094, 'h02308D33, 0, 0, 'h0, 'h1098, 1, 2);
    add_row("jal x27 misalign",  'h1098, 'h00600DEF, 27, 0, 'h0, 'h109C, 1, 0);
    // read back the registers that the faulting words named
    add_row("xor x28,x24,x1",    'h109C, 'h001C4E33, 28, 1, 'h00000005, 'h10A0, 0, 0);
    add_row("add x29,x25,x26",   'h10A0, 'h01AC8EB3, 29, 1, 'h00000000, 'h10A4, 0, 0);
    add_row("sub x30,x1,x27",    'h10A4, 'h41B08F33, 30, 1, 'h00000005, 'h10A8, 0, 0);
endtask

`endif

// File: dv/rv_int_slice_tb.sv
////////////////////////////////////////////////////////////
// testbench that runs a table program through the RV32I
// integer slice under random output stall
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_int_slice_tb;

    logic            clk_i;
    logic            rst_n_i;
    logic            in_valid_i;
    logic            in_ready_o;
    rv_pkg::fetch_t  fetch_i;
    logic            res_valid_o;
    logic            res_ready_i;
    rv_pkg::result_t res_o;

    string           row_name[$];
    rv_pkg::fetch_t  stim_q[$];
    rv_pkg::result_t exp_q[$];

    logic [31:0]     lfsr;
    int              cycles = 0;
    int              cycle_limit;
    int              send_idx;
    int              check_idx;
    logic            hold_seen;
    rv_pkg::result_t held;

    rv_int_slice i_rv_int_slice (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .fetch_i    (fetch_i),
        .res_valid_o(res_valid_o),
        .res_ready_i(res_ready_i),
        .res_o      (res_o)
    );

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic add_row(input string name, input logic [31:0] pc,
                           input logic [31:0] inst, input int rd, input int we,
                           input logic [31:0] value, input logic [31:0] next_pc,
                           input int exc, input int cause);
        rv_pkg::result_t r;
        r.pc        = pc;
        r.rd        = rd[4:0];
        r.reg_we    = we[0];
        r.value     = value;
        r.next_pc   = next_pc;
        r.exc_valid = exc[0];
        r.exc_cause = rv_pkg::exc_cause_t'(cause[3:0]);
        row_name.push_back(name);
        stim_q.push_back({pc, inst});
        exp_q.push_back(r);
    endtask

    `include "rv_tb_table.svh"

    task automatic expect_field(input string test, input string field,
                                input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("error %s %s: expected %h, actual %h", test, field, exp, act);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic compare_result(input int idx);
        rv_pkg::result_t e;
        string           n;
        e = exp_q[idx];
        n = row_name[idx];
        expect_field(n, "pc", e.pc, res_o.pc);
        expect_field(n, "reg_we", 32'(e.reg_we), 32'(res_o.reg_we));
        expect_field(n, "next_pc", e.next_pc, res_o.next_pc);
        expect_field(n, "exc_valid", 32'(e.exc_valid), 32'(res_o.exc_valid));
        if (e.reg_we) begin
            expect_field(n, "rd", 32'(e.rd), 32'(res_o.rd));
            expect_field(n, "value", e.value, res_o.value);
        end
        if (e.exc_valid) begin
            expect_field(n, "exc_cause", 32'(e.exc_cause), 32'(res_o.exc_cause));
        end
    endtask

    // a stalled result must stay valid and unchanged
    task automatic verify_stall();
        if (hold_seen) begin
            assert (res_valid_o) else begin
                $display("res_valid_o dropped while the result was stalled");
                $display("*** FAILED ***");
                $fatal(1);
            end
            assert (res_o === held) else begin
                $display("error %s held result: expected %h, actual %h",
                         row_name[check_idx], held, res_o);
                $display("*** FAILED ***");
                $fatal(1);
            end
        end
        hold_seen = res_valid_o && !res_ready_i;
        held      = res_o;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: %0d of %0d results after %0d cycles",
                     check_idx, exp_q.size(), cycles);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    initial begin
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        fetch_i     = '0;
        res_ready_i = 1'b0;
        lfsr        = 32'h7739;
        send_idx    = 0;
        check_idx   = 0;
        hold_seen   = 1'b0;
        held        = '0;
        load_table();
        cycle_limit = stim_q.size() * 8 + 16;

        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        #10;
        assert (in_ready_o && !res_valid_o) else begin
            $display("in_ready_o low or res_valid_o high after reset");
            $display("*** FAILED ***");
            $fatal(1);
        end

        while (check_idx < exp_q.size()) begin
            @(negedge clk_i);
            lfsr        = lfsr_step(lfsr);
            res_ready_i = lfsr[0];
            in_valid_i  = send_idx < stim_q.size();
            if (send_idx < stim_q.size()) begin
                fetch_i = stim_q[send_idx];
            end
            // settled well before the next rising edge
            #10;
            if (in_valid_i && in_ready_o) begin
                send_idx++;
            end
            verify_stall();
            if (res_valid_o && res_ready_i) begin
                compare_result(check_idx);
                check_idx++;
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+dv
verilog/rv_pkg.sv
verilog/rv_immediate.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_int_slice.sv
dv/rv_int_slice_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rv_int_slice testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module rv_int_slice_tb

# the log is searched below, so a nonzero exit here must not stop the script
./obj_dir/Vrv_int_slice_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    exit 1
fi
exit 0
